// File: design/gobou_config.svh
`ifndef GOBOU_CONFIG_SVH
`define GOBOU_CONFIG_SVH

// number of neurons computed side by side
`define GOBOU_CORE 4
`define GOBOU_CORELOG 2     // net_we is CORELOG+1 bits, 0 means idle

// signed fixed point words, FRAC bits below the binary point
`define GOBOU_DWIDTH 16
`define GOBOU_FRAC 8

// address widths of the image memory and of each net memory
`define GOBOU_IMGSIZE 10
`define GOBOU_NETSIZE 10

`define GOBOU_LWIDTH 10     // totals and loop counters

`endif

// File: design/gobou_ctrl_pkg.sv
package gobou_ctrl_pkg;

  // beat qualifiers passed from the sequencer down the core pipeline
  typedef struct packed {
    logic start;  // clear the accumulator, or result ready on the way back
    logic valid;  // a weight or bias word is on the net bus
    logic stop;   // this beat carries the bias
  } ctrl_reg;

  // sequencer phases of one batch
  typedef enum logic [1:0] {
    s_wait,
    s_weight,
    s_bias,
    s_output
  } ctrl_state;

endpackage

// File: design/gobou_data_pkg.sv
`include "gobou_config.svh"

package gobou_data_pkg;

  // image word, also used for every core result
  typedef logic signed [`GOBOU_DWIDTH-1:0] pixel_t;

  // one net memory word read two ways
  // weight phase reads a multiplicand with FRAC fraction bits
  // bias phase reads a value the core lifts by FRAC before adding
  typedef union packed {
    logic signed [`GOBOU_DWIDTH-1:0] weight;
    logic signed [`GOBOU_DWIDTH-1:0] bias;
  } net_word;

endpackage

// File: design/gobou_mem_img.sv
`timescale 1ns/1ps
`include "gobou_config.svh"

module gobou_mem_img (
  input  logic                      clk,
  input  logic                      we,
  input  logic [`GOBOU_IMGSIZE-1:0] addr,
  input  gobou_data_pkg::pixel_t    wdata,
  output gobou_data_pkg::pixel_t    rdata
);
  import gobou_data_pkg::*;

  pixel_t mem [2**`GOBOU_IMGSIZE];

  // read returns the old word when the same address is written
  always_ff @(posedge clk) begin
    if (we) mem[addr] <= wdata;
    rdata <= mem[addr];
  end

endmodule

// File: design/gobou_mem_net.sv
`timescale 1ns/1ps
`include "gobou_config.svh"

module gobou_mem_net (
  input  logic                           clk,
  input  logic                           we,
  input  logic [`GOBOU_NETSIZE-1:0]      addr,
  input  logic signed [`GOBOU_DWIDTH-1:0] wdata,
  output gobou_data_pkg::net_word        rdata
);
  import gobou_data_pkg::*;

  // holds weights and biases of one core for every batch
  net_word mem [2**`GOBOU_NETSIZE];

  always_ff @(posedge clk) begin
    if (we) mem[addr] <= net_word'(wdata);
    rdata <= mem[addr];  // core picks the view from the phase
  end

endmodule

// File: design/gobou_core.sv
`timescale 1ns/1ps
`include "gobou_config.svh"

module gobou_core (
  input  logic                    clk,
  input  logic                    xrst,
  input  gobou_ctrl_pkg::ctrl_reg in_ctrl,
  input  logic                    breg_we,
  input  gobou_data_pkg::pixel_t  pixel,
  input  gobou_data_pkg::net_word net,
  output gobou_ctrl_pkg::ctrl_reg out_ctrl,
  output gobou_data_pkg::pixel_t  result
);
  import gobou_ctrl_pkg::*;
  import gobou_data_pkg::*;

  localparam int dw    = `GOBOU_DWIDTH;
  localparam int acc_w = 2 * `GOBOU_DWIDTH + `GOBOU_LWIDTH;  // room for total_in products

  localparam logic signed [acc_w-1:0] pos_max = 2**(dw-1) - 1;

  logic signed [acc_w-1:0] r_acc;
  logic signed [dw-1:0]    r_bias;
  logic                    r_stop_d;
  logic signed [2*dw-1:0]  prod;
  logic signed [acc_w-1:0] bias_ext;
  logic signed [acc_w-1:0] sum;
  logic signed [acc_w-1:0] scaled;
  pixel_t                  sat;

  assign prod     = pixel * net.weight;
  assign bias_ext = {{(acc_w - dw){r_bias[dw-1]}}, r_bias};
  assign sum      = r_acc + (bias_ext <<< `GOBOU_FRAC);
  assign scaled   = sum >>> `GOBOU_FRAC;

  // ReLU, then clamp to the largest positive word
  always_comb begin
    if (scaled < 0) sat = '0;
    else if (scaled > pos_max) sat = pos_max[dw-1:0];
    else sat = scaled[dw-1:0];
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_acc    <= '0;
      r_stop_d <= 1'b0;
      out_ctrl <= '0;
    end else begin
      if (in_ctrl.start) r_acc <= '0;
      else if (in_ctrl.valid && !in_ctrl.stop) r_acc <= r_acc + prod;
      r_stop_d <= in_ctrl.valid && in_ctrl.stop;
      // the result leaves as a one word stream, start and stop on the same beat
      out_ctrl.start <= r_stop_d;
      out_ctrl.valid <= r_stop_d;
      out_ctrl.stop  <= r_stop_d;
    end
  end

  always_ff @(posedge clk) begin
    if (breg_we) r_bias <= net.bias;
    if (r_stop_d) result <= sat;  // kept until the next neuron finishes
  end

  // the bias strobe and the bias beat come from separate registers upstream
  a_bias_beat: assert property (@(posedge clk) disable iff (!xrst)
    breg_we |-> in_ctrl.valid && in_ctrl.stop);

endmodule

// File: design/gobou_serializer.sv
`timescale 1ns/1ps
`include "gobou_config.svh"

module gobou_serializer (
  input  logic                                      clk,
  input  logic                                      xrst,
  input  logic                                      load,
  input  gobou_data_pkg::pixel_t [`GOBOU_CORE-1:0] results,
  output gobou_data_pkg::pixel_t                   word
);
  import gobou_data_pkg::*;

  pixel_t [`GOBOU_CORE-1:0] r_shift;
  logic [`GOBOU_CORELOG:0]  r_left;  // words still to be presented

  // core 0 sits at the bottom and leaves first
  always_ff @(posedge clk) begin
    if (load) r_shift <= results;
    else r_shift <= {pixel_t'('0), r_shift[`GOBOU_CORE-1:1]};
  end

  assign word = r_shift[0];

  always_ff @(posedge clk) begin
    if (!xrst) r_left <= '0;
    else if (load) r_left <= `GOBOU_CORE;
    else if (r_left != '0) r_left <= r_left - 1'b1;
  end

  // a new batch may land only while the last word of the old one is out
  a_no_overrun: assert property (@(posedge clk) disable iff (!xrst) load |-> r_left <= 1);

endmodule

// File: design/gobou_ctrl_core.sv
`timescale 1ns/1ps
`include "gobou_config.svh"

module gobou_ctrl_core (
  input  logic                      clk,
  input  logic                      xrst,
  input  gobou_ctrl_pkg::ctrl_reg   in_ctrl,
  input  logic                      req,
  input  logic                      img_we,
  input  logic [`GOBOU_IMGSIZE-1:0] input_addr,
  input  logic [`GOBOU_IMGSIZE-1:0] output_addr,
  input  gobou_data_pkg::pixel_t    write_img,
  input  gobou_data_pkg::pixel_t    write_result,
  input  logic [`GOBOU_CORELOG:0]   net_we,
  input  logic [`GOBOU_NETSIZE-1:0] net_addr,
  input  logic [`GOBOU_LWIDTH-1:0]  total_out,
  input  logic [`GOBOU_LWIDTH-1:0]  total_in,
  output gobou_ctrl_pkg::ctrl_reg   out_ctrl,
  output logic                      ack,
  output logic                      mem_img_we,
  output logic [`GOBOU_IMGSIZE-1:0] mem_img_addr,
  output gobou_data_pkg::pixel_t    write_mem_img,
  output logic [`GOBOU_CORE-1:0]    mem_net_we,
  output logic [`GOBOU_NETSIZE-1:0] mem_net_addr,
  output logic                      breg_we,
  output logic                      serial_we
);
  import gobou_ctrl_pkg::*;
  import gobou_data_pkg::*;

  localparam logic [`GOBOU_LWIDTH-1:0] core_n    = `GOBOU_CORE;
  localparam logic [`GOBOU_CORELOG:0]  last_word = `GOBOU_CORE;

  ctrl_state                 r_state;
  logic [`GOBOU_LWIDTH-1:0]  r_total_in;
  logic [`GOBOU_LWIDTH-1:0]  r_total_out;
  logic [`GOBOU_LWIDTH-1:0]  r_count_in;   // weight beat inside the batch
  logic [`GOBOU_LWIDTH-1:0]  r_count_out;  // first neuron of the batch
  logic [`GOBOU_CORELOG:0]   r_serial_cnt;
  logic [`GOBOU_IMGSIZE-1:0] r_input_offset;
  logic [`GOBOU_IMGSIZE-1:0] r_output_offset;
  logic [`GOBOU_IMGSIZE-1:0] r_input_pos;
  logic [`GOBOU_IMGSIZE-1:0] r_output_pos;
  logic [`GOBOU_NETSIZE-1:0] r_net_offset;
  logic [`GOBOU_NETSIZE-1:0] r_net_pos;
  pixel_t                    r_write_img;
  logic                      weight_end;
  logic                      output_end;
  logic                      last_batch;

  assign weight_end = r_state == s_weight && r_count_in == r_total_in - 1'b1;
  assign output_end = r_state == s_output && r_serial_cnt == last_word;
  assign last_batch = r_count_out + core_n >= r_total_out;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_state     <= s_wait;
      r_count_in  <= '0;
      r_count_out <= '0;
    end else begin
      case (r_state)
        s_wait: begin
          if (req) r_state <= s_weight;
        end
        s_weight: begin
          if (weight_end) begin
            r_state    <= s_bias;
            r_count_in <= '0;
          end else begin
            r_count_in <= r_count_in + 1'b1;
          end
        end
        s_bias: r_state <= s_output;  // a single bias beat per batch
        s_output: begin
          if (output_end && last_batch) begin
            r_state     <= s_wait;
            r_count_out <= '0;
          end else if (output_end) begin
            r_state     <= s_weight;
            r_count_out <= r_count_out + core_n;
          end
        end
        default: r_state <= s_wait;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_total_in  <= '0;
      r_total_out <= '0;
    end else if (r_state == s_wait && req) begin
      r_total_in  <= total_in;
      r_total_out <= total_out;
    end
  end

  // offsets follow the host while idle and freeze once req is taken
  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_input_offset  <= '0;
      r_output_offset <= '0;
      r_net_offset    <= '0;
    end else if (ack) begin
      r_input_offset  <= input_addr;
      r_output_offset <= output_addr;
      r_net_offset    <= net_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      mem_img_we <= 1'b0;
    end else begin
      case (r_state)
        s_wait:   mem_img_we <= img_we;
        s_output: mem_img_we <= serial_we || (r_serial_cnt != '0 && r_serial_cnt < last_word);
        default:  mem_img_we <= 1'b0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    r_write_img <= write_img;
  end

  always_ff @(posedge clk) begin
    if (!xrst || r_state != s_weight) r_input_pos <= '0;
    else r_input_pos <= r_input_pos + 1'b1;  // pixel i goes with weight i
  end

  always_ff @(posedge clk) begin
    if (!xrst || ack) r_output_pos <= '0;
    else if (mem_img_we) r_output_pos <= r_output_pos + 1'b1;  // runs on across batches
  end

  assign mem_img_addr  = r_state == s_output ? r_output_offset + r_output_pos
                                             : r_input_offset + r_input_pos;
  assign write_mem_img = r_state == s_output ? write_result : r_write_img;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      mem_net_we <= '0;
    end else begin
      for (int k = 0; k < `GOBOU_CORE; k++) begin
        mem_net_we[k] <= r_state == s_wait && net_we == k + 1;
      end
    end
  end

  // weights then bias sit back to back, so the next batch starts right after
  always_ff @(posedge clk) begin
    if (!xrst || r_state == s_wait) r_net_pos <= '0;
    else if (r_state == s_weight || r_state == s_bias) r_net_pos <= r_net_pos + 1'b1;
  end

  assign mem_net_addr = r_net_offset + r_net_pos;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      out_ctrl  <= '0;
      breg_we   <= 1'b0;
      serial_we <= 1'b0;
      ack       <= 1'b1;
    end else begin
      out_ctrl.start <= (r_state == s_wait && req) || (output_end && !last_batch);
      out_ctrl.valid <= r_state == s_weight || r_state == s_bias;
      out_ctrl.stop  <= r_state == s_bias;
      breg_we        <= r_state == s_bias;
      serial_we      <= in_ctrl.start;  // results ready in every core
      if (req) ack <= 1'b0;
      else if (output_end && last_batch) ack <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) r_serial_cnt <= '0;
    else if (serial_we) r_serial_cnt <= 1'b1;
    else if (r_serial_cnt == last_word) r_serial_cnt <= '0;
    else if (r_serial_cnt != '0) r_serial_cnt <= r_serial_cnt + 1'b1;
  end

  a_net_we_onehot: assert property (@(posedge clk) disable iff (!xrst) $onehot0(mem_net_we));

  // the host may start a run only while idle
  a_req_idle: assert property (@(posedge clk) disable iff (!xrst) req |-> ack);

endmodule

// File: design/gobou_top.sv
`timescale 1ns/1ps
`include "gobou_config.svh"

module gobou_top (
  input  logic                           clk,
  input  logic                           xrst,
  input  logic                           req,
  input  logic                           img_we,
  input  logic [`GOBOU_IMGSIZE-1:0]      input_addr,
  input  logic [`GOBOU_IMGSIZE-1:0]      output_addr,
  input  gobou_data_pkg::pixel_t         write_img,
  input  logic [`GOBOU_CORELOG:0]        net_we,
  input  logic [`GOBOU_NETSIZE-1:0]      net_addr,
  input  logic signed [`GOBOU_DWIDTH-1:0] write_net,
  input  logic [`GOBOU_LWIDTH-1:0]       total_out,
  input  logic [`GOBOU_LWIDTH-1:0]       total_in,
  output logic                           ack,
  output gobou_data_pkg::pixel_t         read_img
);
  import gobou_ctrl_pkg::*;
  import gobou_data_pkg::*;

  ctrl_reg                   core_ctrl;
  ctrl_reg                   core_out [`GOBOU_CORE];  // lockstep, core 0 reports
  logic                      mem_img_we;
  logic [`GOBOU_IMGSIZE-1:0] mem_img_addr;
  pixel_t                    write_mem_img;
  logic [`GOBOU_CORE-1:0]    mem_net_we;
  logic [`GOBOU_NETSIZE-1:0] mem_net_addr;
  logic                      breg_we;
  logic                      serial_we;
  net_word                   net_rdata [`GOBOU_CORE];
  pixel_t [`GOBOU_CORE-1:0]  core_result;
  pixel_t                    write_result;

  gobou_ctrl_core ctrl_i (
    .clk, .xrst, .in_ctrl(core_out[0]), .req, .img_we, .input_addr, .output_addr,
    .write_img, .write_result, .net_we, .net_addr, .total_out, .total_in,
    .out_ctrl(core_ctrl), .ack, .mem_img_we, .mem_img_addr, .write_mem_img,
    .mem_net_we, .mem_net_addr, .breg_we, .serial_we
  );

  // pixels broadcast to all cores and read back by the host on the same port
  gobou_mem_img mem_img_i (
    .clk, .we(mem_img_we), .addr(mem_img_addr), .wdata(write_mem_img), .rdata(read_img)
  );

  for (genvar k = 0; k < `GOBOU_CORE; k++) begin : g_core
    gobou_mem_net mem_net_i (
      .clk, .we(mem_net_we[k]), .addr(mem_net_addr), .wdata(write_net), .rdata(net_rdata[k])
    );

    gobou_core core_i (
      .clk, .xrst, .in_ctrl(core_ctrl), .breg_we, .pixel(read_img), .net(net_rdata[k]),
      .out_ctrl(core_out[k]), .result(core_result[k])
    );
  end

  gobou_serializer serializer_i (
    .clk, .xrst, .load(serial_we), .results(core_result), .word(write_result)
  );

endmodule

// File: dv/gobou_tb.sv
`timescale 1ns/1ps
`include "gobou_config.svh"

module gobou_tb;

  localparam int core_n    = `GOBOU_CORE;
  localparam int img_depth = 2**`GOBOU_IMGSIZE;
  localparam int net_depth = 2**`GOBOU_NETSIZE;
  localparam int frac      = `GOBOU_FRAC;
  localparam int n_tests   = 4;
  localparam longint pos_max = 2**(`GOBOU_DWIDTH-1) - 1;

  typedef logic signed [`GOBOU_DWIDTH-1:0] word_t;

  logic                      clk;
  logic                      xrst;
  logic                      req;
  logic                      img_we;
  logic [`GOBOU_IMGSIZE-1:0] input_addr;
  logic [`GOBOU_IMGSIZE-1:0] output_addr;
  word_t                     write_img;
  logic [`GOBOU_CORELOG:0]   net_we;
  logic [`GOBOU_NETSIZE-1:0] net_addr;
  word_t                     write_net;
  logic [`GOBOU_LWIDTH-1:0]  total_out;
  logic [`GOBOU_LWIDTH-1:0]  total_in;
  logic                      ack;
  word_t                     read_img;

  word_t img_model [img_depth];          // what the image memory should hold
  word_t net_model [core_n][net_depth];
  int    n_checks;
  int    n_errors;
  int    rb_lo;
  int    rb_hi;
  bit    rb_busy;

  // single batch, three batches, saturation, second run at new offsets
  int test_in   [n_tests] = '{'h040, 'h080, 'h0c0, 'h200};
  int test_out  [n_tests] = '{'h100, 'h140, 'h180, 'h260};
  int test_net  [n_tests] = '{'h000, 'h020, 'h100, 'h180};
  int test_tin  [n_tests] = '{6, 9, 5, 13};
  int test_tout [n_tests] = '{4, 12, 4, 8};
  bit test_big  [n_tests] = '{1'b0, 1'b0, 1'b1, 1'b0};

  gobou_top dut_i (
    .clk(clk), .xrst(xrst), .req(req), .img_we(img_we), .input_addr(input_addr),
    .output_addr(output_addr), .write_img(write_img), .net_we(net_we), .net_addr(net_addr),
    .write_net(write_net), .total_out(total_out), .total_in(total_in), .ack(ack),
    .read_img(read_img)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic word_t fill_word(int a);
    logic [31:0] h;
    h = a * 32'h9e3779b1;  // odd multiplier so every address bit matters
    return h[31:16] ^ 16'(a);
  endfunction

  // one neuron by the result rule, from the tb's copies of the memories
  function automatic word_t neuron_ref(int k, int b, int in_base, int net_base, int t_in);
    longint acc;
    int     wa;
    int     i;
    acc = 0;
    wa  = net_base + b * (t_in + 1);
    for (i = 0; i < t_in; i++) begin
      acc += longint'(img_model[in_base + i]) * longint'(net_model[k][wa + i]);
    end
    acc += longint'(net_model[k][wa + t_in]) <<< frac;  // bias word follows the weights
    acc = acc >>> frac;
    if (acc < 0) return '0;
    if (acc > pos_max) return word_t'(pos_max);
    return word_t'(acc);
  endfunction

  function automatic int watchdog_cycles();
    int cycles;
    int t;
    cycles = 6 * img_depth;  // fill plus two full read-back sweeps
    for (t = 0; t < n_tests; t++) begin
      cycles += test_tout[t] / core_n * (test_tin[t] + core_n + 8);
      cycles += 2 * test_tin[t] + 2 * test_tout[t] * (test_tin[t] + 1);
      cycles += 2 * (test_tout[t] + 8);
    end
    return 2 * cycles + 1000;
  endfunction

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic check(string name, logic [`GOBOU_DWIDTH-1:0] got,
                       logic [`GOBOU_DWIDTH-1:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // address and enable are registered inside, so the word lands on the second edge
  task automatic write_img_word(int a, word_t d);
    input_addr = a[`GOBOU_IMGSIZE-1:0];
    write_img  = d;
    img_we     = 1'b1;
    step();
    img_we = 1'b0;
    step();
    img_model[a] = d;
  endtask

  task automatic write_net_word(int k, int a, word_t d);
    net_addr  = a[`GOBOU_NETSIZE-1:0];
    write_net = d;  // not registered upstream, so it stays put for both cycles
    net_we    = 3'(k + 1);
    step();
    net_we = '0;
    step();
    net_model[k][a] = d;
  endtask

  task automatic read_img_word(int a, output word_t d);
    input_addr = a[`GOBOU_IMGSIZE-1:0];
    img_we     = 1'b0;
    step();
    step();
    d = read_img;
  endtask

  task automatic readback(int lo, int hi);
    rb_lo   = lo;
    rb_hi   = hi;
    rb_busy = 1'b1;
    wait (rb_busy == 1'b0);
  endtask

  task automatic load_test(int t);
    word_t v;
    int    b;
    int    k;
    int    i;
    for (i = 0; i < test_tin[t]; i++) begin
      if (test_big[t]) v = 16'($urandom_range(16'h7fff, 16'h1000));
      else v = 16'($urandom_range(1023, 0)) - 16'd512;
      write_img_word(test_in[t] + i, v);
    end
    for (b = 0; b < test_tout[t] / core_n; b++) begin
      for (k = 0; k < core_n; k++) begin
        for (i = 0; i <= test_tin[t]; i++) begin
          if (i == test_tin[t] && test_big[t]) v = 16'($urandom);
          else if (i == test_tin[t]) v = 16'($urandom_range(4095, 0)) - 16'd2048;
          else if (test_big[t] && k % 2 == 0) v = 16'($urandom_range(16'h7fff, 16'h4000));
          else if (test_big[t]) v = -16'($urandom_range(16'h7fff, 16'h4000));
          else v = 16'($urandom_range(1023, 0)) - 16'd512;
          write_net_word(k, test_net[t] + b * (test_tin[t] + 1) + i, v);
        end
      end
    end
  endtask

  task automatic run_engine(int t);
    input_addr  = test_in[t][`GOBOU_IMGSIZE-1:0];
    output_addr = test_out[t][`GOBOU_IMGSIZE-1:0];
    net_addr    = test_net[t][`GOBOU_NETSIZE-1:0];
    total_in    = test_tin[t][`GOBOU_LWIDTH-1:0];
    total_out   = test_tout[t][`GOBOU_LWIDTH-1:0];
    req         = 1'b1;
    step();
    req = 1'b0;
    while (ack !== 1'b1) step();
  endtask

  task automatic check_outputs(int t);
    word_t exp;
    int    j;
    for (j = 0; j < test_tout[t]; j++) begin
      exp = neuron_ref(j % core_n, j / core_n, test_in[t], test_net[t], test_tin[t]);
      // even cores must clip high and odd cores must clip to zero here
      if (test_big[t] && exp != ((j % 2 == 0) ? word_t'(pos_max) : word_t'(0))) begin
        n_errors++;
        $display("saturation stimulus for output %0d did not reach its limit", j);
      end
      img_model[test_out[t] + j] = exp;
    end
    readback(test_out[t] - 4, test_out[t] + test_tout[t] + 3);
  endtask

  initial begin : read_back
    word_t got;
    int    a;
    forever begin
      wait (rb_busy);
      for (a = rb_lo; a <= rb_hi; a++) begin
        read_img_word(a, got);
        check($sformatf("read_img[%0d]", a), got, img_model[a]);
      end
      rb_busy = 1'b0;
    end
  end

  initial begin : watchdog
    int limit;
    limit = watchdog_cycles();
    repeat (limit) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", limit);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin : stimulus
    int a;
    int t;
    xrst        = 1'b0;
    req         = 1'b0;
    img_we      = 1'b0;
    input_addr  = '0;
    output_addr = '0;
    write_img   = '0;
    net_we      = '0;
    net_addr    = '0;
    write_net   = '0;
    total_out   = '0;
    total_in    = '0;
    n_checks    = 0;
    n_errors    = 0;
    rb_busy     = 1'b0;
    void'($urandom(32'h38e21cd6));
    repeat (3) @(posedge clk);
    #1 xrst = 1'b1;
    step();
    check("ack", {15'b0, ack}, 16'h1);
    for (a = 0; a < img_depth; a++) write_img_word(a, fill_word(a));
    readback(0, img_depth - 1);
    for (t = 0; t < n_tests; t++) begin
      load_test(t);
      run_engine(t);
      check_outputs(t);
    end
    readback(0, img_depth - 1);  // nothing outside the output windows moved
    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) $display("RESULT: PASS");
    else $display("RESULT: FAIL");
    $finish;
  end

endmodule

// File: sim.f
+incdir+design
design/gobou_ctrl_pkg.sv
design/gobou_data_pkg.sv
design/gobou_mem_img.sv
design/gobou_mem_net.sv
design/gobou_core.sv
design/gobou_serializer.sv
design/gobou_ctrl_core.sv
design/gobou_top.sv
dv/gobou_tb.sv

// File: run.sh
#!/bin/sh
# build the gobou testbench with Verilator, run it and scan the log
rm -f sim.log \
  && verilator --binary --timing --assert -Wno-fatal -j 0 --top-module gobou_tb \
       -f sim.f -o gobou_sim \
  && ./obj_dir/gobou_sim | tee sim.log \
  && grep -q "^RESULT: PASS$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
